// File: bench/conv_store_tb.sv
`timescale 1ns/1ps
`include "conv_store_defines.svh"

module conv_store_tb;
  import conv_store_pkg::*;

  localparam logic [31:0] seed = 32'h7b20_2edb;

  logic clk;
  logic reset;
  logic start = 1'b0;
  tile_cfg_t cfg = '0;
  logic ddr_cmd_ready = 1'b0;
  logic ddr_data_ready = 1'b0;
  logic [`CS_DDR_WORD_W-1:0] fifo_data = '0;
  logic [`CS_FIFO_NUM-1:0] fifo_rds;
  store_cmd_t store_cmd;
  logic store_cmd_valid;
  logic [`CS_DDR_WORD_W-1:0] ddr_data;
  logic [`CS_ADR_W-1:0] ddr_adr;
  logic ddr_data_valid;
  logic fin;

  // expected tile, filled by the reference model
  logic [`CS_DDR_WORD_W-1:0] exp_words[$];
  logic [`CS_ADR_W-1:0] exp_adrs[$];
  store_cmd_t exp_cmds[$];
  int exp_fifos[$];

  tile_cfg_t tests[4];
  string names[4];
  logic rand_sel[4];
  string test_name = "reset";
  logic rand_ready = 1'b0;
  logic [31:0] rng = seed;
  int rd_cnt[`CS_FIFO_NUM];
  int words_seen;
  int reads_seen;
  int cmds_seen;
  int fin_seen;
  int errors = 0;
  int checks = 0;
  int test_errs = 0;
  int limit;

  tb_clock_gen clk_gen0 (.clk(clk), .reset(reset));

  conv_store_top dut0 (
    .clk             (clk),
    .reset           (reset),
    .start           (start),
    .cfg             (cfg),
    .ddr_cmd_ready   (ddr_cmd_ready),
    .ddr_data_ready  (ddr_data_ready),
    .fifo_data       (fifo_data),
    .fifo_rds        (fifo_rds),
    .store_cmd       (store_cmd),
    .store_cmd_valid (store_cmd_valid),
    .ddr_data        (ddr_data),
    .ddr_adr         (ddr_adr),
    .ddr_data_valid  (ddr_data_valid),
    .fin             (fin)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // entry n of fifo f
  function automatic logic [`CS_DDR_WORD_W-1:0] fifo_entry(input int f, input int n);
    logic [`CS_DDR_WORD_W-1:0] e;
    logic [31:0] s;
    s = seed ^ (f * 32'h0101_0101) ^ (n * 32'h9e37_79b9);
    if (s == 32'd0) s = 32'd1;
    for (int i = 0; i < 16; i++) begin
      s = xorshift(s);
      e[i*32 +: 32] = s;
    end
    return e;
  endfunction

  function automatic tile_cfg_t make_cfg(input store_mode_t mode, input logic [31:0] base,
                                         input int ox0, input int oy0, input int of0,
                                         input int pof, input int poy);
    tile_cfg_t c;
    c.mode       = mode;
    c.layer_base = base;
    c.of_log2    = 4'd7;
    c.ox_log2    = 4'd5;
    c.ox_start   = ox0;
    c.oy_start   = oy0;
    c.of_start   = of0;
    c.pof        = pof;
    c.poy        = poy;
    return c;
  endfunction

  // address of the pair holding odd channel ch on row oy
  function automatic logic [31:0] pair_adr(input tile_cfg_t c, input int oy, input int ch);
    logic [31:0] y;
    logic [31:0] x;
    logic [31:0] f;
    y = c.oy_start + oy - 2;
    x = c.ox_start - 1;
    f = c.of_start + ch - 2;
    return c.layer_base + (y << (c.of_log2 - 1 + c.ox_log2 - 5))
         + ((x << (c.of_log2 - 1)) >> 5) + (f >> 1);
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic void build_expected(input tile_cfg_t c);
    int cnt[`CS_FIFO_NUM];
    int row_log;
    int pairs;
    int f_lo;
    int f_hi;
    logic [`CS_DDR_WORD_W-1:0] lo;
    logic [`CS_DDR_WORD_W-1:0] hi;
    store_cmd_t cmd;
    exp_words.delete();
    exp_adrs.delete();
    exp_cmds.delete();
    exp_fifos.delete();
    foreach (cnt[i]) cnt[i] = 0;
    row_log = (c.mode == MODE_HALF) ? 4 : 5;
    pairs = c.pof / 2;
    for (int oy = 1; oy <= c.poy; oy++) begin
      for (int p = 0; p < pairs; p += 32) begin
        cmd.base = pair_adr(c, oy, 2 * p + 1);
        cmd.len  = (pairs - p > 32) ? 32 : (pairs - p);
        exp_cmds.push_back(cmd);
      end
      for (int ch = 1; ch < c.pof; ch += 2) begin
        f_lo = (oy - 1) * 4 + ((ch - 1) >> row_log);
        lo = fifo_entry(f_lo, cnt[f_lo]);
        cnt[f_lo]++;
        exp_fifos.push_back(f_lo);
        if (c.mode == MODE_HALF) begin
          f_hi = (oy - 1) * 4 + (ch >> row_log);
          hi = fifo_entry(f_hi, cnt[f_hi]);
          cnt[f_hi]++;
          exp_fifos.push_back(f_hi);
          exp_words.push_back({hi[255:0], lo[255:0]});
        end else begin
          exp_words.push_back(lo);
        end
        exp_adrs.push_back(pair_adr(c, oy, ch));
      end
    end
  endfunction

  task automatic compare(input string what, input logic [511:0] exp, input logic [511:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errs++;
      $display("mismatch %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    test_errs++;
    $display("error in %s: %s", test_name, msg);
  endtask

  // ready levels are random or held high
  always @(posedge clk) begin
    if (rand_ready) begin
      rng = xorshift(rng);
      ddr_cmd_ready  <= rng[2];
      ddr_data_ready <= rng[0] | rng[1];
    end else begin
      ddr_cmd_ready  <= 1'b1;
      ddr_data_ready <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // fifo model answers one cycle after the strobe
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : fifo_model
    int idx;
    int ones;
    if (!reset && fifo_rds != '0) begin
      idx = 0;
      ones = 0;
      for (int i = 0; i < `CS_FIFO_NUM; i++) begin
        if (fifo_rds[i]) begin
          idx = i;
          ones++;
        end
      end
      if (ones > 1) report_error("more than one fifo read strobe is high");
      if (reads_seen < exp_fifos.size()) begin
        compare("fifo index", exp_fifos[reads_seen], idx);
      end else begin
        report_error("fifo read after the last read of the tile");
      end
      reads_seen++;
      fifo_data <= fifo_entry(idx, rd_cnt[idx]);
      rd_cnt[idx]++;
    end
  end

  // command and word monitor
  always @(posedge clk) begin
    if (!reset && store_cmd_valid) begin
      if (cmds_seen < exp_cmds.size()) begin
        compare("cmd base", exp_cmds[cmds_seen].base, store_cmd.base);
        compare("cmd len", exp_cmds[cmds_seen].len, store_cmd.len);
      end else begin
        report_error("store command issued after the last burst");
      end
      cmds_seen++;
    end
    if (!reset && ddr_data_valid) begin
      if (!ddr_data_ready) report_error("data valid while ddr_data_ready is low");
      if (words_seen < exp_words.size()) begin
        compare("word adr", exp_adrs[words_seen], ddr_adr);
        compare("word data", exp_words[words_seen], ddr_data);
        compare("fin", words_seen == exp_words.size() - 1, fin);
      end else begin
        report_error("ddr word delivered after the last word of the tile");
      end
      words_seen++;
    end
    if (!reset && !ddr_data_valid) begin
      if (ddr_data !== '0 || ddr_adr !== '0) begin
        report_error("ddr data or address is nonzero while data valid is low");
      end
    end
    if (!reset && fin) fin_seen++;
  end

  task automatic run_tile(input string name, input tile_cfg_t c, input logic rnd);
    @(negedge clk);
    test_name = name;
    test_errs = 0;
    build_expected(c);
    words_seen = 0;
    reads_seen = 0;
    cmds_seen = 0;
    fin_seen = 0;
    foreach (rd_cnt[i]) rd_cnt[i] = 0;
    rand_ready = rnd;
    @(posedge clk);
    cfg   <= c;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (words_seen < exp_words.size()) @(negedge clk);
    // quiet period to catch stray reads, commands or fin
    rand_ready = 1'b0;
    repeat (10) @(negedge clk);
    compare("word count", exp_words.size(), words_seen);
    compare("read count", exp_fifos.size(), reads_seen);
    compare("cmd count", exp_cmds.size(), cmds_seen);
    compare("fin count", 1, fin_seen);
    $display("test %s: %0d words, %0d errors", name, words_seen, test_errs);
  endtask

  initial begin
    tests[0] = make_cfg(MODE_FULL, 32'h0001_0000, 3, 2, 1, 24, 1);
    tests[1] = make_cfg(MODE_HALF, 32'h0002_0000, 1, 1, 1, 64, 3);
    tests[2] = tests[1];
    tests[3] = make_cfg(MODE_FULL, 32'h0040_0000, 5, 3, 3, 80, 2);
    names[0] = "full_one_row";
    names[1] = "half_three_rows";
    names[2] = "half_random_ready";
    names[3] = "full_second_base";
    rand_sel[0] = 1'b0;
    rand_sel[1] = 1'b0;
    rand_sel[2] = 1'b1;
    rand_sel[3] = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    compare("store_cmd_valid", 0, store_cmd_valid);
    compare("fifo_rds", 0, fifo_rds);
    compare("ddr_data_valid", 0, ddr_data_valid);
    compare("fin", 0, fin);
    $display("test reset: %0d errors", test_errs);
    wait (!reset);
    for (int t = 0; t < 4; t++) begin
      run_tile(names[t], tests[t], rand_sel[t]);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog allows 40 cycles per expected word plus margin
  initial begin
    #1;
    limit = 2000;
    for (int t = 0; t < 4; t++) begin
      limit += 40 * (tests[t].pof / 2) * tests[t].poy;
    end
    repeat (limit) @(posedge clk);
    $display("timeout in %s after %0d cycles", test_name, limit);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: conv_store.f
+incdir+rtl
rtl/conv_store_pkg.sv
rtl/store_cmd_gen.sv
rtl/fifo_read_seq.sv
rtl/ddr_word_pack.sv
rtl/conv_store_top.sv
bench/tb_clock_gen.sv
bench/conv_store_tb.sv

// File: rtl/conv_store_defines.svh
`ifndef CONV_STORE_DEFINES_SVH
`define CONV_STORE_DEFINES_SVH

////////////////////////////////////////////////////////////
// fifo array
////////////////////////////////////////////////////////////

`define CS_FIFO_ROWS 4
`define CS_FIFO_COLS 3
`define CS_FIFO_NUM (`CS_FIFO_ROWS * `CS_FIFO_COLS)

// data widths
`define CS_CONV_WORD_W 256
`define CS_DDR_WORD_W 512

////////////////////////////////////////////////////////////
// ddr layout and bursts
////////////////////////////////////////////////////////////

`define CS_CMD_WORDS 32
`define CS_OFS_PER_WORD_LOG2 1
`define CS_PIXELS_ROW_LOG2 5
`define CS_ROW_CH_HALF 16
`define CS_ROW_CH_HALF_LOG2 4

`define CS_IDX_W 16
`define CS_ADR_W 32

`endif

// File: rtl/conv_store_pkg.sv
`include "conv_store_defines.svh"

package conv_store_pkg;

  // half packs two reads per ddr word, full one
  typedef enum logic {
    MODE_HALF = 1'b0,
    MODE_FULL = 1'b1
  } store_mode_t;

  typedef enum logic [1:0] {
    CMD_IDLE  = 2'd0,
    CMD_ISSUE = 2'd1,
    CMD_BURST = 2'd2
  } cmd_state_t;

  // tile setup, captured on start
  typedef struct packed {
    store_mode_t          mode;
    logic [`CS_ADR_W-1:0] layer_base;
    logic [3:0]           of_log2;
    logic [3:0]           ox_log2;
    logic [`CS_IDX_W-1:0] ox_start;
    logic [`CS_IDX_W-1:0] oy_start;
    logic [`CS_IDX_W-1:0] of_start;
    logic [`CS_IDX_W-1:0] pof;
    logic [`CS_IDX_W-1:0] poy;
  } tile_cfg_t;

  typedef struct packed {
    logic [`CS_ADR_W-1:0] base;
    logic [`CS_IDX_W-1:0] len;
  } store_cmd_t;

  // rides along with every fifo read
  typedef struct packed {
    logic [`CS_ADR_W-1:0] adr;
    logic                 word_done;
    logic                 burst_last;
    logic                 tile_last;
  } rd_tag_t;

endpackage

// File: rtl/conv_store_top.sv
`timescale 1ns/1ps
`include "conv_store_defines.svh"

module conv_store_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  conv_store_pkg::tile_cfg_t  cfg,
  input  logic                       ddr_cmd_ready,
  input  logic                       ddr_data_ready,
  input  logic [`CS_DDR_WORD_W-1:0]  fifo_data,
  output logic [`CS_FIFO_NUM-1:0]    fifo_rds,
  output conv_store_pkg::store_cmd_t store_cmd,
  output logic                       store_cmd_valid,
  output logic [`CS_DDR_WORD_W-1:0]  ddr_data,
  output logic [`CS_ADR_W-1:0]       ddr_adr,
  output logic                       ddr_data_valid,
  output logic                       fin
);
  import conv_store_pkg::*;

  tile_cfg_t tile_cfg;
  rd_tag_t rd_tag;
  logic rd;
  logic pack_free;
  logic burst_done;
  logic tile_done;

  // command side
  store_cmd_gen cmd_gen0 (
    .clk             (clk),
    .reset           (reset),
    .start           (start),
    .cfg             (cfg),
    .ddr_cmd_ready   (ddr_cmd_ready),
    .burst_done      (burst_done),
    .tile_done       (tile_done),
    .store_cmd       (store_cmd),
    .store_cmd_valid (store_cmd_valid),
    .tile_cfg        (tile_cfg)
  );

  fifo_read_seq read_seq0 (
    .clk             (clk),
    .reset           (reset),
    .tile_cfg        (tile_cfg),
    .store_cmd       (store_cmd),
    .store_cmd_valid (store_cmd_valid),
    .pack_free       (pack_free),
    .fifo_rds        (fifo_rds),
    .rd              (rd),
    .rd_tag          (rd_tag)
  );

  // data side
  ddr_word_pack word_pack0 (
    .clk            (clk),
    .reset          (reset),
    .mode           (tile_cfg.mode),
    .ddr_data_ready (ddr_data_ready),
    .rd             (rd),
    .rd_tag         (rd_tag),
    .fifo_data      (fifo_data),
    .pack_free      (pack_free),
    .ddr_data       (ddr_data),
    .ddr_adr        (ddr_adr),
    .ddr_data_valid (ddr_data_valid),
    .fin            (fin),
    .burst_done     (burst_done),
    .tile_done      (tile_done)
  );

endmodule

// File: rtl/ddr_word_pack.sv
`timescale 1ns/1ps
`include "conv_store_defines.svh"

module ddr_word_pack (
  input  logic                        clk,
  input  logic                        reset,
  input  conv_store_pkg::store_mode_t mode,
  input  logic                        ddr_data_ready,
  input  logic                        rd,
  input  conv_store_pkg::rd_tag_t     rd_tag,
  input  logic [`CS_DDR_WORD_W-1:0]   fifo_data,
  output logic                        pack_free,
  output logic [`CS_DDR_WORD_W-1:0]   ddr_data,
  output logic [`CS_ADR_W-1:0]        ddr_adr,
  output logic                        ddr_data_valid,
  output logic                        fin,
  output logic                        burst_done,
  output logic                        tile_done
);
  import conv_store_pkg::*;

  logic rd_q;
  rd_tag_t tag_q;
  logic [`CS_CONV_WORD_W-1:0] prev_low;
  logic word_now;
  logic [`CS_DDR_WORD_W-1:0] new_word;

  // word parked while ddr is not ready
  logic hold_valid;
  logic [`CS_DDR_WORD_W-1:0] hold_data;
  rd_tag_t hold_tag;

  logic [`CS_DDR_WORD_W-1:0] cur_data;
  rd_tag_t cur_tag;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= rd;
    end
  end

  // tag lines up with fifo_data one cycle after the strobe
  always_ff @(posedge clk) begin
    if (rd) begin
      tag_q <= rd_tag;
    end
    if (rd_q) begin
      prev_low <= fifo_data[`CS_CONV_WORD_W-1:0];
    end
  end

  assign word_now = rd_q && tag_q.word_done;
  assign new_word = (mode == MODE_FULL) ? fifo_data
                                        : {fifo_data[`CS_CONV_WORD_W-1:0], prev_low};

  always_ff @(posedge clk) begin
    if (reset) begin
      hold_valid <= 1'b0;
    end else if (word_now && !ddr_data_ready) begin
      hold_valid <= 1'b1;
    end else if (hold_valid && ddr_data_ready) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (word_now) begin
      hold_data <= new_word;
      hold_tag  <= tag_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // ddr side
  ////////////////////////////////////////////////////////////

  assign pack_free = !hold_valid && !word_now;

  assign cur_data = hold_valid ? hold_data : new_word;
  assign cur_tag = hold_valid ? hold_tag : tag_q;

  assign ddr_data_valid = (hold_valid || word_now) && ddr_data_ready;
  assign ddr_data = ddr_data_valid ? cur_data : '0;
  assign ddr_adr = ddr_data_valid ? cur_tag.adr : '0;

  assign burst_done = ddr_data_valid && cur_tag.burst_last;
  assign tile_done = ddr_data_valid && cur_tag.tile_last;
  assign fin = tile_done;

endmodule

// File: rtl/fifo_read_seq.sv
`timescale 1ns/1ps
`include "conv_store_defines.svh"

module fifo_read_seq (
  input  logic                       clk,
  input  logic                       reset,
  input  conv_store_pkg::tile_cfg_t  tile_cfg,
  input  conv_store_pkg::store_cmd_t store_cmd,
  input  logic                       store_cmd_valid,
  input  logic                       pack_free,
  output logic [`CS_FIFO_NUM-1:0]    fifo_rds,
  output logic                       rd,
  output conv_store_pkg::rd_tag_t    rd_tag
);
  import conv_store_pkg::*;

  localparam logic [`CS_IDX_W-1:0] ch_half = `CS_ROW_CH_HALF;
  localparam logic [3:0] log_half = `CS_ROW_CH_HALF_LOG2;
  localparam logic [`CS_IDX_W-1:0] fifo_rows = `CS_FIFO_ROWS;
  localparam logic [`CS_FIFO_NUM-1:0] rd_one = 1;

  logic half;
  logic burst_open;
  logic [`CS_IDX_W-1:0] reads_left;
  logic [`CS_ADR_W-1:0] word_adr;

  // channel inside the fifo row, 1-based
  logic [`CS_IDX_W-1:0] ch;
  // first channel held by the current fifo row
  logic [`CS_IDX_W-1:0] row_base;
  logic [`CS_IDX_W-1:0] oy;

  logic [`CS_IDX_W-1:0] ch_step;
  logic [`CS_IDX_W-1:0] row_ch;
  logic [3:0] row_log;
  logic row_end;
  logic fifo_row_end;
  logic [`CS_IDX_W-1:0] fifo_idx;
  logic word_done;
  logic burst_last;

  assign half = (tile_cfg.mode == MODE_HALF);
  assign ch_step = half ? 16'd1 : 16'd2;
  assign row_ch = half ? ch_half : (ch_half << 1);
  assign row_log = half ? log_half : (log_half + 4'd1);

  // end of the output row vs end of one fifo row
  assign row_end = (row_base + ch + ch_step - 16'd1) > tile_cfg.pof;
  assign fifo_row_end = row_end || (ch + ch_step > row_ch);

  assign fifo_idx = (oy - 16'd1) * fifo_rows + ((row_base - 16'd1) >> row_log);

  // odd channel only fills the low half
  assign word_done = !half || !ch[0];
  assign burst_last = (reads_left == 16'd1);

  assign rd = burst_open && pack_free;
  assign fifo_rds = rd ? (rd_one << fifo_idx) : '0;

  assign rd_tag = '{
    adr:        word_adr,
    word_done:  word_done,
    burst_last: burst_last,
    tile_last:  row_end && (oy == tile_cfg.poy)
  };

  ////////////////////////////////////////////////////////////
  // burst tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      burst_open <= 1'b0;
      reads_left <= '0;
    end else if (store_cmd_valid) begin
      burst_open <= 1'b1;
      reads_left <= half ? (store_cmd.len << 1) : store_cmd.len;
    end else if (rd) begin
      reads_left <= reads_left - 16'd1;
      if (burst_last) begin
        burst_open <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (store_cmd_valid) begin
      word_adr <= store_cmd.base;
    end else if (rd && word_done) begin
      word_adr <= word_adr + 32'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // channel / fifo row / oy walk
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      ch       <= 16'd1;
      row_base <= 16'd1;
      oy       <= 16'd1;
    end else if (rd) begin
      if (fifo_row_end) begin
        ch <= 16'd1;
        if (row_end) begin
          row_base <= 16'd1;
          oy       <= (oy == tile_cfg.poy) ? 16'd1 : (oy + 16'd1);
        end else begin
          row_base <= row_base + row_ch;
        end
      end else begin
        ch <= ch + ch_step;
      end
    end
  end

endmodule

// File: rtl/store_cmd_gen.sv
`timescale 1ns/1ps
`include "conv_store_defines.svh"

module store_cmd_gen (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  conv_store_pkg::tile_cfg_t cfg,
  input  logic                      ddr_cmd_ready,
  input  logic                      burst_done,
  input  logic                      tile_done,
  output conv_store_pkg::store_cmd_t store_cmd,
  output logic                      store_cmd_valid,
  output conv_store_pkg::tile_cfg_t tile_cfg
);
  import conv_store_pkg::*;

  localparam logic [`CS_IDX_W-1:0] max_len = `CS_CMD_WORDS;
  localparam logic [5:0] ofs_sh = `CS_OFS_PER_WORD_LOG2;
  localparam logic [5:0] word_sh = `CS_OFS_PER_WORD_LOG2 + `CS_PIXELS_ROW_LOG2;

  cmd_state_t state;
  logic issue;

  // 1-based channel and row of the next burst
  logic [`CS_IDX_W-1:0] ch_cnt;
  logic [`CS_IDX_W-1:0] row_cnt;

  logic [`CS_IDX_W-1:0] pairs_left;
  logic [`CS_IDX_W-1:0] cmd_len;
  logic [`CS_IDX_W-1:0] ch_step;

  logic [`CS_IDX_W-1:0] row_idx;
  logic [`CS_IDX_W-1:0] x_idx;
  logic [`CS_IDX_W-1:0] ch_idx;
  logic [5:0] row_sh;
  logic [5:0] x_sh;
  logic [`CS_ADR_W-1:0] row_ofs;
  logic [`CS_ADR_W-1:0] x_ofs;
  logic [`CS_ADR_W-1:0] ch_ofs;
  logic [`CS_ADR_W-1:0] cmd_base;

  assign issue = (state == CMD_ISSUE) && ddr_cmd_ready;

  // burst length, capped by what is left of the row
  assign pairs_left = (tile_cfg.pof - ch_cnt + 16'd1) >> `CS_OFS_PER_WORD_LOG2;
  assign cmd_len = (pairs_left > max_len) ? max_len : pairs_left;
  assign ch_step = cmd_len << `CS_OFS_PER_WORD_LOG2;

  ////////////////////////////////////////////////////////////
  // base address of the first pair in the burst
  ////////////////////////////////////////////////////////////

  assign row_idx = tile_cfg.oy_start + row_cnt - 16'd2;
  assign x_idx = tile_cfg.ox_start - 16'd1;
  assign ch_idx = tile_cfg.of_start + ch_cnt - 16'd2;
  assign row_sh = {2'b00, tile_cfg.of_log2} + {2'b00, tile_cfg.ox_log2} - word_sh;
  assign x_sh = {2'b00, tile_cfg.of_log2} - ofs_sh;

  assign row_ofs = {{(`CS_ADR_W-`CS_IDX_W){1'b0}}, row_idx} << row_sh;
  assign x_ofs = ({{(`CS_ADR_W-`CS_IDX_W){1'b0}}, x_idx} << x_sh) >> `CS_PIXELS_ROW_LOG2;
  assign ch_ofs = {{(`CS_ADR_W-`CS_IDX_W){1'b0}}, ch_idx} >> `CS_OFS_PER_WORD_LOG2;
  assign cmd_base = tile_cfg.layer_base + row_ofs + x_ofs + ch_ofs;

  always_ff @(posedge clk) begin
    if (start && (state == CMD_IDLE)) begin
      tile_cfg <= cfg;
    end
  end

  ////////////////////////////////////////////////////////////
  // command fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state           <= CMD_IDLE;
      store_cmd_valid <= 1'b0;
      ch_cnt          <= 16'd1;
      row_cnt         <= 16'd1;
    end else begin
      store_cmd_valid <= issue;
      case (state)
        CMD_IDLE: begin
          if (start) begin
            state   <= CMD_ISSUE;
            ch_cnt  <= 16'd1;
            row_cnt <= 16'd1;
          end
        end
        CMD_ISSUE: begin
          if (ddr_cmd_ready) begin
            state <= CMD_BURST;
            // row finished, move to next oy
            if (ch_cnt + ch_step > tile_cfg.pof) begin
              ch_cnt  <= 16'd1;
              row_cnt <= row_cnt + 16'd1;
            end else begin
              ch_cnt <= ch_cnt + ch_step;
            end
          end
        end
        CMD_BURST: begin
          if (tile_done) begin
            state <= CMD_IDLE;
          end else if (burst_done) begin
            state <= CMD_ISSUE;
          end
        end
        default: state <= CMD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      store_cmd.base <= cmd_base;
      store_cmd.len  <= cmd_len;
    end
  end

endmodule
